//--- logic/adc_pkg.sv
`default_nettype none

////////////////////
// adc slice definitions
////////////////////

package adc_pkg;

    // number of time-interleaved slices
    localparam int NTI = 4;

    // magnitude code width of one slice
    localparam int NADC = 8;

    // raw magnitude code as delivered by a slice
    typedef logic [NADC-1:0] adc_code_t;

    // unfolded two's complement sample, also used for the threshold
    typedef logic signed [NADC-1:0] adc_sample_t;

endpackage

`default_nettype wire

//--- logic/prbs_pkg.sv
`default_nettype none

////////////////////
// prbs7 definitions
////////////////////

package prbs_pkg;

    // sequence order
    localparam int NPRBS = 7;

    // feedback delays in serial bits
    // b[n] = b[n-7] ^ b[n-6]
    localparam int PRBS_TAP_A = 7;
    localparam int PRBS_TAP_B = 6;

    // generator reset state, must be nonzero
    localparam logic [NPRBS-1:0] PRBS_SEED = 7'h5a;

    // error and total counter width
    localparam int NCOUNT = 32;

    typedef logic [NCOUNT-1:0] prbs_count_t;

endpackage

`default_nettype wire

//--- logic/adc_slicer.sv
`default_nettype none
`timescale 1ns/1ns

module adc_slicer #(
    parameter int NTI  = 4,
    parameter int NADC = 8
) (
    input  wire logic                          clk_adc,
    input  wire logic                          rst_n_i,
    input  wire adc_pkg::adc_code_t [NTI-1:0]  adc_code_i,
    input  wire logic [NTI-1:0]                adc_sign_i,
    input  wire adc_pkg::adc_sample_t          thresh_i,
    output logic [NTI-1:0]                     bits_o
);

    // one extra bit so that a full-scale magnitude keeps its sign
    logic signed [NADC:0] sample [NTI];
    logic signed [NADC:0] thresh_ext;
    logic [NTI-1:0]       cmp;

    // sign extension of the programmed threshold
    assign thresh_ext = thresh_i;

    ////////////////////
    // unfold and compare
    ////////////////////

    genvar k;
    generate
        for (k = 0; k < NTI; k = k + 1) begin : g_slice
            // sign bit 1 means positive sample
            assign sample[k] = adc_sign_i[k] ?
                               $signed({1'b0, adc_code_i[k]}) :
                               -$signed({1'b0, adc_code_i[k]});

            // strictly greater than threshold
            assign cmp[k] = (sample[k] > thresh_ext);
        end
    endgenerate

    ////////////////////
    // decision register
    ////////////////////

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= cmp;
        end
    end

    // each decision appears one cycle after its code and sign
    generate
        for (k = 0; k < NTI; k = k + 1) begin : g_chk
            a_bit_follows_cmp : assert property (
                @(posedge clk_adc) disable iff (!rst_n_i)
                !$isunknown(adc_sign_i[k]) |=>
                    bits_o[k] == ($past(adc_sign_i[k]) ?
                                  (int'($past(adc_code_i[k])) > int'($past(thresh_i))) :
                                  (-int'($past(adc_code_i[k])) > int'($past(thresh_i))))
            ) else $error("slicer bit %0d does not follow its comparison", k);
        end
    endgenerate

endmodule

`default_nettype wire

//--- logic/prbs_bist_gen.sv
`default_nettype none
`timescale 1ns/1ns

module prbs_bist_gen #(
    parameter int NTI = 4
) (
    input  wire logic           clk_adc,
    input  wire logic           rst_n_i,
    input  wire logic           cke_i,
    input  wire logic           inj_err_i,
    output logic [NTI-1:0]      bits_o
);

    localparam int NSTATE = prbs_pkg::NPRBS;
    localparam int NEXT   = NSTATE + NTI;

    // state holds the last NSTATE serial bits
    // bit 0 is the oldest, bit NSTATE-1 the newest
    logic [NSTATE-1:0] state;
    logic [NEXT-1:0]   ext;
    logic [NTI-1:0]    word;
    logic [NTI-1:0]    inj_mask;

    ////////////////////
    // unrolled lfsr
    ////////////////////

    // each new bit looks back along the extended vector
    always_comb begin
        ext = {{NTI{1'b0}}, state};
        for (int i = 0; i < NTI; i++) begin
            ext[NSTATE+i] = ext[NSTATE+i-prbs_pkg::PRBS_TAP_A]
                          ^ ext[NSTATE+i-prbs_pkg::PRBS_TAP_B];
        end
    end

    assign word = ext[NEXT-1:NSTATE];

    // channel 0 is the earliest bit of the word
    assign inj_mask = NTI'(inj_err_i);

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= prbs_pkg::PRBS_SEED;
        end else if (cke_i) begin
            state <= ext[NEXT-1 -: NSTATE];
        end
    end

    ////////////////////
    // output register
    ////////////////////

    // injection only touches the output, never the state
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bits_o <= '0;
        end else if (cke_i) begin
            bits_o <= word ^ inj_mask;
        end
    end

    // an all-zero state would lock the generator
    a_state_nonzero : assert property (
        @(posedge clk_adc) disable iff (!rst_n_i)
        state != '0
    ) else $error("bist lfsr reached the all-zero state");

endmodule

`default_nettype wire

//--- logic/prbs_checker.sv
`default_nettype none
`timescale 1ns/1ns

module prbs_checker #(
    parameter int NTI = 4
) (
    input  wire logic              clk_adc,
    input  wire logic              rst_n_i,
    input  wire logic              cke_i,
    input  wire logic              sel_src_i,
    input  wire logic [NTI-1:0]    adc_bits_i,
    input  wire logic [NTI-1:0]    bist_bits_i,
    input  wire logic [NTI-1:0]    chan_sel_i,
    output prbs_pkg::prbs_count_t  err_count_o,
    output prbs_pkg::prbs_count_t  total_count_o
);

    localparam int NHIST  = prbs_pkg::NPRBS;
    localparam int NEXT   = NHIST + NTI;
    // words needed before the history is full
    localparam int NWARM  = (NHIST + NTI - 1) / NTI;
    localparam int WARM_W = $clog2(NWARM + 1);
    localparam int POP_W  = $clog2(NTI + 1);

    logic [NTI-1:0]    rx_bits;
    logic [NHIST-1:0]  hist;
    logic [NEXT-1:0]   ext;
    logic [NTI-1:0]    pred;
    logic [NTI-1:0]    err_bits;
    logic [WARM_W-1:0] warm_cnt;
    logic              warm_done;
    logic [POP_W-1:0]  n_sel;
    logic [POP_W-1:0]  n_err;

    function automatic logic [POP_W-1:0] popcount(input logic [NTI-1:0] v);
        logic [POP_W-1:0] n;
        n = '0;
        for (int i = 0; i < NTI; i++) begin
            n = n + POP_W'(v[i]);
        end
        return n;
    endfunction

    // sticks at all ones instead of wrapping
    function automatic prbs_pkg::prbs_count_t sat_add(
        input prbs_pkg::prbs_count_t a,
        input logic [POP_W-1:0]      b
    );
        logic [prbs_pkg::NCOUNT:0] sum;
        sum = a + b;
        if (sum[prbs_pkg::NCOUNT]) begin
            return '1;
        end
        return sum[prbs_pkg::NCOUNT-1:0];
    endfunction

    ////////////////////
    // source select
    ////////////////////

    assign rx_bits = sel_src_i ? bist_bits_i : adc_bits_i;

    ////////////////////
    // self-sync check
    ////////////////////

    // history below, current word above, oldest bit at index 0
    assign ext = {rx_bits, hist};

    // later channels see the earlier bits of the same word
    always_comb begin
        for (int i = 0; i < NTI; i++) begin
            pred[i] = ext[NHIST+i-prbs_pkg::PRBS_TAP_A]
                    ^ ext[NHIST+i-prbs_pkg::PRBS_TAP_B];
        end
    end

    assign err_bits = rx_bits ^ pred;

    // masked channels still feed the history
    always_ff @(posedge clk_adc) begin
        if (cke_i) begin
            hist <= ext[NEXT-1 -: NHIST];
        end
    end

    assign warm_done = (warm_cnt == WARM_W'(NWARM));

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            warm_cnt <= '0;
        end else if (cke_i && !warm_done) begin
            warm_cnt <= warm_cnt + 1'b1;
        end
    end

    ////////////////////
    // counters
    ////////////////////

    assign n_sel = popcount(chan_sel_i);
    assign n_err = popcount(err_bits & chan_sel_i);

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_count_o   <= '0;
            total_count_o <= '0;
        end else if (cke_i && warm_done) begin
            err_count_o   <= sat_add(err_count_o, n_err);
            total_count_o <= sat_add(total_count_o, n_sel);
        end
    end

    // every counted error is also a counted bit
    a_err_le_total : assert property (
        @(posedge clk_adc) disable iff (!rst_n_i)
        err_count_o <= total_count_o
    ) else $error("error count above total count");

endmodule

`default_nettype wire

//--- logic/digital_core.sv
`default_nettype none
`timescale 1ns/1ns

module digital_core #(
    parameter int NTI  = adc_pkg::NTI,
    parameter int NADC = adc_pkg::NADC
) (
    input  wire logic                          clk_adc,
    input  wire logic                          rst_n_i,

    // adc slices
    input  wire adc_pkg::adc_code_t [NTI-1:0]  adc_code_i,
    input  wire logic [NTI-1:0]                adc_sign_i,
    input  wire adc_pkg::adc_sample_t          thresh_i,

    // prbs test controls
    input  wire logic                          sel_src_i,
    input  wire logic                          cke_i,
    input  wire logic                          inj_err_i,
    input  wire logic [NTI-1:0]                chan_sel_i,

    output wire logic [NTI-1:0]                slice_bits_o,
    output wire prbs_pkg::prbs_count_t         err_count_o,
    output wire prbs_pkg::prbs_count_t         total_count_o
);

    wire logic [NTI-1:0] adc_bits;
    wire logic [NTI-1:0] bist_bits;

    ////////////////////
    // adc decisions
    ////////////////////

    adc_slicer #(
        .NTI  (NTI),
        .NADC (NADC)
    ) slicer_i (
        .clk_adc    (clk_adc),
        .rst_n_i    (rst_n_i),
        .adc_code_i (adc_code_i),
        .adc_sign_i (adc_sign_i),
        .thresh_i   (thresh_i),
        .bits_o     (adc_bits)
    );

    assign slice_bits_o = adc_bits;

    ////////////////////
    // bist source
    ////////////////////

    prbs_bist_gen #(
        .NTI (NTI)
    ) bist_gen_i (
        .clk_adc   (clk_adc),
        .rst_n_i   (rst_n_i),
        .cke_i     (cke_i),
        .inj_err_i (inj_err_i),
        .bits_o    (bist_bits)
    );

    ////////////////////
    // bit-error checker
    ////////////////////

    // sel_src_i picks bist bits when high
    prbs_checker #(
        .NTI (NTI)
    ) checker_i (
        .clk_adc       (clk_adc),
        .rst_n_i       (rst_n_i),
        .cke_i         (cke_i),
        .sel_src_i     (sel_src_i),
        .adc_bits_i    (adc_bits),
        .bist_bits_i   (bist_bits),
        .chan_sel_i    (chan_sel_i),
        .err_count_o   (err_count_o),
        .total_count_o (total_count_o)
    );

endmodule

`default_nettype wire

//--- dv/tb_tests.svh
////////////////////
// slicer decisions
////////////////////

// the check at each step covers the inputs of the step before
task automatic slicer_random();
    adc_pkg::adc_code_t [NTI-1:0] codes;
    logic [NTI-1:0]               signs;
    adc_pkg::adc_sample_t         th;
    logic [NTI-1:0]               exp_now;
    logic [NTI-1:0]               exp_prev;
    logic [31:0]                  r;
    exp_prev = '0;
    for (int i = 0; i <= SLICER_LEN; i++) begin
        @(posedge clk_adc);
        for (int k = 0; k < NTI; k++) begin
            r = next_random();
            codes[k] = r[23:16];
            signs[k] = r[31];
        end
        r = next_random();
        th = r[23:16];
        adc_code <= codes;
        adc_sign <= signs;
        thresh   <= th;
        exp_now = slicer_expect(codes, signs, th);
        @(negedge clk_adc);
        if (i > 0) begin
            compare_value("slice_bits_o", slice_bits, exp_prev);
        end
        exp_prev = exp_now;
    end
endtask

////////////////////
// bist checks
////////////////////

task automatic bist_clean_window();
    prbs_pkg::prbs_count_t err0;
    prbs_pkg::prbs_count_t tot0;
    @(posedge clk_adc);
    sel_src  <= 1'b1;
    chan_sel <= '1;
    cke      <= 1'b1;
    repeat (SETTLE_LEN) @(posedge clk_adc);
    @(negedge clk_adc);
    err0 = err_count;
    tot0 = total_count;
    repeat (WINDOW_LEN) @(posedge clk_adc);
    @(negedge clk_adc);
    compare_value("bist total delta", total_count - tot0, WINDOW_LEN * NTI);
    compare_value("bist error delta", err_count - err0, 0);
endtask

task automatic bist_injected_error();
    prbs_pkg::prbs_count_t err0;
    @(negedge clk_adc);
    err0 = err_count;
    @(posedge clk_adc);
    inj_err <= 1'b1;
    @(posedge clk_adc);
    inj_err <= 1'b0;
    repeat (INJECT_WAIT) @(posedge clk_adc);
    @(negedge clk_adc);
    compare_value("injected error delta", err_count - err0, affected_errors(0, '1));
endtask

// one injection inside a window with a random channel mask
task automatic channel_mask_window();
    prbs_pkg::prbs_count_t err0;
    prbs_pkg::prbs_count_t tot0;
    logic [NTI-1:0]        mask;
    logic [31:0]           r;
    do begin
        r = next_random();
        mask = r[16 +: NTI];
    end while (mask == '0);
    $display("channel mask %b", mask);
    @(posedge clk_adc);
    chan_sel <= mask;
    repeat (2) @(posedge clk_adc);
    @(negedge clk_adc);
    err0 = err_count;
    tot0 = total_count;
    for (int i = 0; i < WINDOW_LEN; i++) begin
        @(posedge clk_adc);
        if (i == INJECT_AT) begin
            inj_err <= 1'b1;
        end else begin
            inj_err <= 1'b0;
        end
    end
    @(negedge clk_adc);
    compare_value("masked total delta", total_count - tot0, WINDOW_LEN * $countones(mask));
    compare_value("masked error delta", err_count - err0, affected_errors(0, mask));
    @(posedge clk_adc);
    chan_sel <= '1;
endtask

////////////////////
// adc path
////////////////////

// prbs word as signs with nonzero magnitudes
task automatic drive_adc_word(input logic [NTI-1:0] flip);
    adc_pkg::adc_code_t [NTI-1:0] codes;
    logic [31:0]                  r;
    @(posedge clk_adc);
    for (int k = 0; k < NTI; k++) begin
        r = next_random();
        codes[k] = (r[23:16] == 8'd0) ? 8'd1 : r[23:16];
    end
    adc_code <= codes;
    adc_sign <= prbs_word() ^ flip;
endtask

task automatic adc_prbs_path();
    prbs_pkg::prbs_count_t err0;
    prbs_pkg::prbs_count_t tot0;
    @(posedge clk_adc);
    sel_src  <= 1'b0;
    thresh   <= '0;
    chan_sel <= '1;
    repeat (SETTLE_LEN) drive_adc_word('0);
    @(negedge clk_adc);
    err0 = err_count;
    tot0 = total_count;
    repeat (WINDOW_LEN) drive_adc_word('0);
    @(negedge clk_adc);
    compare_value("adc total delta", total_count - tot0, WINDOW_LEN * NTI);
    compare_value("adc error delta", err_count - err0, 0);
    // one wrong sign on channel 1
    err0 = err_count;
    drive_adc_word(NTI'(2));
    repeat (6) drive_adc_word('0);
    @(negedge clk_adc);
    compare_value("adc flipped sign delta", err_count - err0, affected_errors(1, '1));
endtask

////////////////////
// clock enable
////////////////////

task automatic clock_enable_hold();
    prbs_pkg::prbs_count_t err0;
    prbs_pkg::prbs_count_t tot0;
    @(posedge clk_adc);
    sel_src <= 1'b1;
    repeat (SETTLE_LEN) @(posedge clk_adc);
    cke <= 1'b0;
    @(negedge clk_adc);
    err0 = err_count;
    tot0 = total_count;
    repeat (HOLD_LEN) @(posedge clk_adc);
    @(negedge clk_adc);
    compare_value("held error count", err_count, err0);
    compare_value("held total count", total_count, tot0);
    @(posedge clk_adc);
    cke <= 1'b1;
    repeat (SETTLE_LEN) @(posedge clk_adc);
endtask

//--- dv/tb_digital_core.sv
`default_nettype none
`timescale 1ns/1ns

module tb_digital_core;

    localparam int NTI          = adc_pkg::NTI;
    localparam int NADC         = adc_pkg::NADC;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;

    // test lengths in clock cycles
    localparam int SLICER_LEN  = 200;
    localparam int WINDOW_LEN  = 100;
    localparam int SETTLE_LEN  = 10;
    localparam int HOLD_LEN    = 20;
    localparam int INJECT_WAIT = 4;
    localparam int INJECT_AT   = 10;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + SLICER_LEN + 3 * WINDOW_LEN
                                  + 5 * SETTLE_LEN + HOLD_LEN + 200;

    logic                          clk_adc = 1'b0;
    logic                          rst_n;
    adc_pkg::adc_code_t [NTI-1:0]  adc_code;
    logic [NTI-1:0]                adc_sign;
    adc_pkg::adc_sample_t          thresh;
    logic                          sel_src;
    logic                          cke;
    logic                          inj_err;
    logic [NTI-1:0]                chan_sel;
    wire logic [NTI-1:0]           slice_bits;
    wire prbs_pkg::prbs_count_t    err_count;
    wire prbs_pkg::prbs_count_t    total_count;

    int                            errors;
    int                            checks;
    int                            cycle_count = 0;
    logic [31:0]                   rand_state;
    // serial prbs model, bit 0 oldest
    logic [prbs_pkg::NPRBS-1:0]    model_hist;

    digital_core #(
        .NTI  (NTI),
        .NADC (NADC)
    ) dut (
        .clk_adc       (clk_adc),
        .rst_n_i       (rst_n),
        .adc_code_i    (adc_code),
        .adc_sign_i    (adc_sign),
        .thresh_i      (thresh),
        .sel_src_i     (sel_src),
        .cke_i         (cke),
        .inj_err_i     (inj_err),
        .chan_sel_i    (chan_sel),
        .slice_bits_o  (slice_bits),
        .err_count_o   (err_count),
        .total_count_o (total_count)
    );

    always #(CLK_PERIOD / 2) clk_adc = ~clk_adc;

    // run limit
    always @(posedge clk_adc) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    ////////////////////
    // reference models
    ////////////////////

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // next NTI serial bits, channel 0 first
    // b[n] = b[n-TAP_A] ^ b[n-TAP_B]
    function automatic logic [NTI-1:0] prbs_word();
        logic [NTI-1:0] w;
        logic           b;
        for (int i = 0; i < NTI; i++) begin
            b = model_hist[prbs_pkg::NPRBS - prbs_pkg::PRBS_TAP_A]
              ^ model_hist[prbs_pkg::NPRBS - prbs_pkg::PRBS_TAP_B];
            model_hist = {b, model_hist[prbs_pkg::NPRBS-1:1]};
            w[i] = b;
        end
        return w;
    endfunction

    function automatic logic [NTI-1:0] slicer_expect(
        input adc_pkg::adc_code_t [NTI-1:0] codes,
        input logic [NTI-1:0]               signs,
        input adc_pkg::adc_sample_t         th
    );
        logic [NTI-1:0] bits;
        int             sample;
        for (int k = 0; k < NTI; k++) begin
            // sign 1 unfolds to plus magnitude
            sample = signs[k] ? int'(codes[k]) : -int'(codes[k]);
            bits[k] = (sample > int'(th));
        end
        return bits;
    endfunction

    // a flipped bit and the two later bits that use it as a tap
    function automatic int affected_errors(input int first_ch, input logic [NTI-1:0] mask);
        int offsets [3];
        int n;
        offsets = '{0, prbs_pkg::PRBS_TAP_B, prbs_pkg::PRBS_TAP_A};
        n = 0;
        foreach (offsets[j]) begin
            if (mask[(first_ch + offsets[j]) % NTI]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    `include "tb_tests.svh"

    initial begin
        errors     = 0;
        checks     = 0;
        rand_state = 32'hacac_6df3;
        model_hist = 7'h3b;
        rst_n      = 1'b0;
        adc_code   = '0;
        adc_sign   = '0;
        thresh     = '0;
        sel_src    = 1'b1;
        cke        = 1'b1;
        inj_err    = 1'b0;
        chan_sel   = '1;

        repeat (RESET_CYCLES) @(posedge clk_adc);
        @(negedge clk_adc);
        compare_value("slice_bits_o in reset", slice_bits, 0);
        compare_value("err_count_o in reset", err_count, 0);
        compare_value("total_count_o in reset", total_count, 0);
        @(posedge clk_adc);
        rst_n <= 1'b1;

        slicer_random();
        bist_clean_window();
        bist_injected_error();
        channel_mask_window();
        adc_prbs_path();
        clock_enable_hold();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+dv
logic/adc_pkg.sv
logic/prbs_pkg.sv
logic/adc_slicer.sv
logic/prbs_bist_gen.sv
logic/prbs_checker.sv
logic/digital_core.sv
dv/tb_digital_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the digital_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_digital_core
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "failure reported in $LOG"
    exit 1
fi

echo "no failure reported in $LOG"
exit 0
